// ==== mem_cfg_pkg.sv ====
package mem_cfg_pkg;

  // Geometry of one chip
  localparam int CHIP_DEPTH       = 4096;   // Words per chip
  localparam int NIBBLE_W         = 4;      // Data pins per chip
  localparam int NIBBLES_PER_WORD = 4;      // Chips side by side in a bank
  localparam int MAX_BANKS        = 4;      // Bank field can name this many

  // Derived widths
  localparam int CHIP_ADDR_W = $clog2(CHIP_DEPTH);         // 12
  localparam int BANK_SEL_W  = $clog2(MAX_BANKS);          // 2
  localparam int WORD_W      = NIBBLE_W * NIBBLES_PER_WORD; // 16
  localparam int WORD_ADDR_W = BANK_SEL_W + CHIP_ADDR_W;   // 14

  // Address inside one chip
  typedef logic [CHIP_ADDR_W-1:0] chip_addr_t;

  // One chip's data
  typedef logic [NIBBLE_W-1:0] nibble_t;

  // One CPU word
  typedef logic [WORD_W-1:0] word_t;

  // Bank field, top of the word address
  typedef logic [BANK_SEL_W-1:0] bank_sel_t;

  // Full word address, bank above chip address
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;

endpackage

// ==== mem_bus_pkg.sv ====
package mem_bus_pkg;

  // CPU request, valid with the req strobe
  typedef struct packed {
    logic                   we;     // 1 = write, 0 = read
    mem_cfg_pkg::word_addr_t addr;  // Bank and chip address
    mem_cfg_pkg::word_t      wdata; // Write word, ignored on reads
  } cpu_req_t;

  // Chip control for the active bank
  // All bits active high here, decode turns them into chip pins
  typedef struct packed {
    logic ce;       // Chip enable for the addressed bank
    logic we;       // Write enable, shared by all chips
    logic latch;    // Load address and write word
    logic capture;  // Take the read word into rdata
  } chip_ctl_t;

  // Phases of one access
  typedef enum logic [2:0] {
    IDLE,    // Waiting for req
    SETUP,   // Address and data settle on the chip pins
    ACCESS,  // Chip enabled, data-in register loads
    HOLD,    // Array written or read register loaded
    FINISH   // done and bank_err out
  } cyc_state_t;

  // Fixed cycle count from accepting edge to done sample
  localparam int CYCLE_LEN = 4;

endpackage

// ==== sram_4kx4.sv ====
`timescale 1ns/100ps

module sram_4kx4 (
  input  logic                    clk,      // Falling edge samples the pins
  input  logic                    reset_n,  // Clears the read register
  input  mem_cfg_pkg::chip_addr_t addr,
  input  logic                    ce_n,     // Chip enable, active low
  input  logic                    we_n,     // Write enable, active low
  input  mem_cfg_pkg::nibble_t    din,
  output mem_cfg_pkg::nibble_t    dout
);

  import mem_cfg_pkg::*;

  nibble_t mem_array [CHIP_DEPTH];  // Block RAM storage
  nibble_t din_q;                   // Data-in register
  nibble_t dout_q;                  // Read register
  logic    ce_n_q;                  // Enable seen at the last falling edge

  // Enable is registered so dout follows the sampled cycle
  always_ff @(negedge clk) begin
    ce_n_q <= ce_n;
  end

  // Data-in register loads on every enabled edge
  // The array takes the value loaded one edge earlier
  always_ff @(negedge clk) begin
    if (!ce_n) begin
      din_q <= din;
      if (!we_n)
        mem_array[addr] <= din_q;  // Write uses previous din
    end
  end

  // Read port
  always_ff @(negedge clk) begin
    if (!reset_n) begin
      dout_q <= '0;
    end else if (!ce_n && we_n) begin
      dout_q <= mem_array[addr];   // Registered read
    end
  end

  // Pins float to zero unless enabled and reading
  assign dout = (!ce_n_q && we_n) ? dout_q : '0;

endmodule

// ==== mem_bank_decode.sv ====
`timescale 1ns/100ps

module mem_bank_decode #(
  parameter int NUM_BANKS = 2   // 1, 2 or 4
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  mem_cfg_pkg::word_addr_t addr_in,    // Raw request address
  input  mem_bus_pkg::chip_ctl_t  chip_ctl,   // Phase strobes from the FSM
  output logic [NUM_BANKS-1:0]    ce_n,       // One enable per bank, active low
  output logic                    we_n,       // Shared by every chip
  output mem_cfg_pkg::chip_addr_t chip_addr,
  output mem_cfg_pkg::bank_sel_t  bank_sel,
  output logic                    addr_valid  // Bank field below NUM_BANKS
);

  import mem_cfg_pkg::*;

  word_addr_t addr_q;   // Address held for the whole access

  // Address register
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      addr_q <= '0;
    end else if (chip_ctl.latch) begin
      addr_q <= addr_in;            // Taken on the accepting edge
    end
  end

  // Field split
  assign bank_sel  = addr_q[WORD_ADDR_W-1 -: BANK_SEL_W];  // Top bits
  assign chip_addr = addr_q[CHIP_ADDR_W-1:0];             // Low bits

  // Out-of-range banks still run a cycle, just with no chip enabled
  assign addr_valid = (int'(bank_sel) < NUM_BANKS);

  // Shared write strobe, high when idle since we follows ce
  assign we_n = ~chip_ctl.we;

  // Per-bank chip enable
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank_ce
    assign ce_n[b] = ~(chip_ctl.ce && addr_valid &&
                       (bank_sel == bank_sel_t'(b)));  // Only the selected bank
  end

endmodule

// ==== mem_data_path.sv ====
`timescale 1ns/100ps

module mem_data_path #(
  parameter int NUM_BANKS = 2   // 1, 2 or 4
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  mem_cfg_pkg::word_t      wdata_in,   // Write word of the request
  input  mem_bus_pkg::chip_ctl_t  chip_ctl,
  input  logic [NUM_BANKS-1:0]    ce_n,       // From decode, active low
  input  logic                    we_n,
  input  mem_cfg_pkg::chip_addr_t chip_addr,
  input  mem_cfg_pkg::bank_sel_t  bank_sel,
  input  logic                    addr_valid,
  output mem_cfg_pkg::word_t      rdata
);

  import mem_cfg_pkg::*;

  word_t   wdata_q;                                  // Held write word
  nibble_t rd_nib   [NUM_BANKS][NIBBLES_PER_WORD];   // Chip outputs
  word_t   bank_word [NUM_BANKS];                    // Reassembled per bank
  word_t   sel_word;                                 // Word of the addressed bank

  // Write word register, loaded with the address
  always_ff @(posedge clk) begin
    if (chip_ctl.latch)
      wdata_q <= wdata_in;
  end

  // Chip array, NIBBLES_PER_WORD chips side by side per bank
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    for (genvar n = 0; n < NIBBLES_PER_WORD; n++) begin : g_chip
      sram_4kx4 u_chip (
        .clk     (clk),
        .reset_n (reset_n),
        .addr    (chip_addr),                       // Shared by all chips
        .ce_n    (ce_n[b]),                         // Bank enable
        .we_n    (we_n),
        .din     (wdata_q[n*NIBBLE_W +: NIBBLE_W]), // Own nibble
        .dout    (rd_nib[b][n])
      );
    end
  end

  // Nibbles back into words, chip 0 is the low nibble
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int n = 0; n < NIBBLES_PER_WORD; n++) begin
        bank_word[b][n*NIBBLE_W +: NIBBLE_W] = rd_nib[b][n];
      end
    end
  end

  // Bank mux
  always_comb begin
    sel_word = '0;  // Default for an unmatched bank field
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (bank_sel == bank_sel_t'(b))
        sel_word = bank_word[b];
    end
  end

  // Read word register
  // Only reads raise capture, so writes leave it alone
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rdata <= '0;
    end else if (chip_ctl.capture) begin
      rdata <= addr_valid ? sel_word : '0;  // Out of range reads as zero
    end
  end

endmodule

// ==== mem_cycle_ctrl.sv ====
`timescale 1ns/100ps

module mem_cycle_ctrl (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   req,        // One-cycle request strobe
  input  logic                   req_we,     // Operation of the request
  input  logic                   addr_valid, // From decode, for bank_err
  output mem_bus_pkg::chip_ctl_t chip_ctl,
  output logic                   busy,
  output logic                   done,
  output logic                   bank_err
);

  import mem_bus_pkg::*;

  cyc_state_t state;
  cyc_state_t state_nxt;
  logic       op_we;     // Stored operation, 1 = write
  logic       accept;    // Request taken this cycle

  // Requests only count in IDLE
  // Anything strobed while busy is dropped
  assign accept = req && (state == IDLE);

  // Next state
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (accept) state_nxt = SETUP;
      SETUP:   state_nxt = ACCESS;  // Pins settle
      ACCESS:  state_nxt = HOLD;    // First enabled falling edge
      HOLD:    state_nxt = FINISH;  // Second enabled falling edge
      FINISH:  state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  // State register
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Operation register
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      op_we <= 1'b0;
    end else if (accept) begin
      op_we <= req_we;
    end
  end

  // Phase strobes
  always_comb begin
    chip_ctl.latch   = accept;                            // Loads on T0
    chip_ctl.ce      = (state == ACCESS) || (state == HOLD);
    // A write enables from ACCESS too; that first edge stores a stale
    // nibble which the HOLD edge overwrites at the same address
    chip_ctl.we      = chip_ctl.ce && op_we;
    chip_ctl.capture = (state == HOLD) && !op_we;         // rdata loads on T3
  end

  // Status outputs
  assign busy     = (state != IDLE);                  // Four cycles per access
  assign done     = (state == FINISH);                // One-cycle pulse
  assign bank_err = (state == FINISH) && !addr_valid; // Pulses with done

endmodule

// ==== mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top #(
  parameter int NUM_BANKS = 2   // Banks fitted, 1, 2 or 4
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  req,       // One-cycle strobe
  input  mem_bus_pkg::cpu_req_t req_info,  // Valid with req
  output logic                  busy,
  output logic                  done,
  output logic                  bank_err,
  output mem_cfg_pkg::word_t    rdata
);

  import mem_cfg_pkg::*;
  import mem_bus_pkg::*;

  chip_ctl_t            chip_ctl;    // FSM phase strobes
  logic [NUM_BANKS-1:0] ce_n;        // Per-bank chip enables
  logic                 we_n;
  chip_addr_t           chip_addr;
  bank_sel_t            bank_sel;
  logic                 addr_valid;

  // Sequencer
  mem_cycle_ctrl u_ctrl (
    .clk        (clk),
    .reset_n    (reset_n),
    .req        (req),
    .req_we     (req_info.we),
    .addr_valid (addr_valid),
    .chip_ctl   (chip_ctl),
    .busy       (busy),
    .done       (done),
    .bank_err   (bank_err)
  );

  // Address latch and chip enables
  mem_bank_decode #(
    .NUM_BANKS (NUM_BANKS)
  ) u_decode (
    .clk        (clk),
    .reset_n    (reset_n),
    .addr_in    (req_info.addr),
    .chip_ctl   (chip_ctl),
    .ce_n       (ce_n),
    .we_n       (we_n),
    .chip_addr  (chip_addr),
    .bank_sel   (bank_sel),
    .addr_valid (addr_valid)
  );

  // Chip array and data registers
  mem_data_path #(
    .NUM_BANKS (NUM_BANKS)
  ) u_data (
    .clk        (clk),
    .reset_n    (reset_n),
    .wdata_in   (req_info.wdata),
    .chip_ctl   (chip_ctl),
    .ce_n       (ce_n),
    .we_n       (we_n),
    .chip_addr  (chip_addr),
    .bank_sel   (bank_sel),
    .addr_valid (addr_valid),
    .rdata      (rdata)
  );

endmodule

// ==== tb_mem_subsys.sv ====
`timescale 1ns/100ps

module tb_mem_subsys;

  import mem_cfg_pkg::*;
  import mem_bus_pkg::*;

  localparam int NUM_BANKS    = 2;
  localparam int CLK_HALF     = 4;                        // 8 ns period
  localparam int RESET_CYC    = 5;
  localparam int VALID_WORDS  = NUM_BANKS * CHIP_DEPTH;   // Words behind real chips
  localparam int N_WRITES     = 48;
  localparam int N_READS      = 48;
  localparam int N_MIXED      = 32;
  localparam int N_DIRECTED   = 16;                       // Bank, range and drop tests
  localparam int N_OPS        = N_WRITES + N_READS + N_MIXED + N_DIRECTED;
  localparam int WATCHDOG_CYC = N_OPS * 6 + RESET_CYC + 100;
  localparam int DONE_WAIT    = 10;                       // Cycles allowed for done

  logic     clk;
  logic     reset_n;
  logic     req;
  cpu_req_t req_info;
  logic     busy;
  logic     done;
  logic     bank_err;
  word_t    rdata;

  logic [31:0] lfsr = 32'h50820bcd;
  word_t       ref_mem [VALID_WORDS];  // Reference memory
  bit          known [VALID_WORDS];    // Word written at least once
  word_addr_t  written_q [$];          // Addresses with a known word
  word_t       exp_rdata = '0;         // rdata expected at the next done
  logic        exp_err   = 1'b0;       // bank_err expected at the next done
  logic [3:0]  acc_hist  = '0;         // Accepted requests, newest in bit 0
  int          cyc       = 0;          // Rising edges seen

  mem_subsys_top #(
    .NUM_BANKS (NUM_BANKS)
  ) u_dut (
    .clk      (clk),
    .reset_n  (reset_n),
    .req      (req),
    .req_info (req_info),
    .busy     (busy),
    .done     (done),
    .bank_err (bank_err),
    .rdata    (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "testbench stopped on first error");
  endtask

  task automatic mismatch(input string sig, input logic [31:0] expv, input logic [31:0] actv);
    stop_run($sformatf("MISMATCH time %0t %s expected 0x%0h actual 0x%0h",
                       $time, sig, expv, actv));
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Bank field 0 or 1, any chip address
  function automatic word_addr_t rand_addr();
    return word_addr_t'(take_bits(CHIP_ADDR_W + 1));
  endfunction

  function automatic word_addr_t pick_written();
    return written_q[take_bits(16) % written_q.size()];
  endfunction

  // Acceptance seen from outside: req while busy is low
  always @(posedge clk) begin
    cyc      <= cyc + 1;
    acc_hist <= {acc_hist[2:0], req && !busy && reset_n};
  end

  // Idle outputs and cleared rdata around reset
  a_reset_state: assert property (@(posedge clk)
    (cyc >= 1 && cyc <= RESET_CYC + 2) |-> (!busy && !done && !bank_err && rdata == '0))
    else stop_run("outputs left their reset values during or right after reset");

  // done exactly 4 edges after the accepting edge
  a_done_latency: assert property (@(posedge clk) disable iff (!reset_n)
    done == acc_hist[3])
    else mismatch("done", 32'($sampled(acc_hist[3])), 32'($sampled(done)));

  // busy over the 4 cycles in between
  a_busy_window: assert property (@(posedge clk) disable iff (!reset_n)
    busy == (|acc_hist))
    else mismatch("busy", 32'($sampled(|acc_hist)), 32'($sampled(busy)));

  a_read_data: assert property (@(posedge clk) disable iff (!reset_n)
    done |-> rdata == exp_rdata)
    else mismatch("rdata", 32'($sampled(exp_rdata)), 32'($sampled(rdata)));

  a_bank_err: assert property (@(posedge clk) disable iff (!reset_n)
    bank_err == (done && exp_err))
    else mismatch("bank_err", 32'($sampled(done && exp_err)), 32'($sampled(bank_err)));

  // Expected outcome of the request just driven
  task automatic expect_access(input logic we, input word_addr_t addr, input word_t wdata);
    logic valid;
    valid = int'(addr) < VALID_WORDS;  // Bank field below NUM_BANKS
    exp_err <= !valid;
    if (we) begin
      if (valid) begin
        if (!known[int'(addr)])
          written_q.push_back(addr);
        known[int'(addr)]   = 1'b1;
        ref_mem[int'(addr)] = wdata;
      end
    end else begin
      exp_rdata <= valid ? ref_mem[int'(addr)] : '0;  // Missing bank reads zero
    end
  endtask

  task automatic drive_req(input logic we, input word_addr_t addr, input word_t wdata);
    @(posedge clk);
    req      <= 1'b1;
    req_info <= '{we: we, addr: addr, wdata: wdata};
  endtask

  // Drop the strobe, then wait for done
  task automatic finish_req();
    int waited;
    waited = 0;
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    while (!done) begin
      waited++;
      if (waited > DONE_WAIT)
        stop_run("done did not arrive after an accepted request");
      @(negedge clk);
    end
  endtask

  task automatic run_access(input logic we, input word_addr_t addr, input word_t wdata);
    drive_req(we, addr, wdata);
    expect_access(we, addr, wdata);
    finish_req();
  endtask

  initial begin
    word_addr_t a;
    word_t      w;
    chip_addr_t c;
    reset_n  <= 1'b0;
    req      <= 1'b0;
    req_info <= '0;
    repeat (RESET_CYC) @(posedge clk);
    reset_n <= 1'b1;
    repeat (2) @(posedge clk);

    for (int i = 0; i < N_WRITES; i++)  // Fill both banks
      run_access(1'b1, rand_addr(), word_t'(take_bits(16)));
    for (int i = 0; i < N_READS; i++)   // Read back known words only
      run_access(1'b0, pick_written(), '0);
    for (int i = 0; i < N_MIXED; i++) begin
      if (take_bits(1) == 1)
        run_access(1'b1, rand_addr(), word_t'(take_bits(16)));
      else
        run_access(1'b0, pick_written(), '0);
    end

    // Same chip address in both banks
    c = chip_addr_t'(take_bits(CHIP_ADDR_W));
    w = word_t'(take_bits(16));
    run_access(1'b1, {2'd0, c}, w);
    run_access(1'b1, {2'd1, c}, ~w);
    run_access(1'b0, {2'd0, c}, '0);
    run_access(1'b0, {2'd1, c}, '0);

    // Banks 2 and 3 are not fitted
    run_access(1'b1, {2'd2, c}, 16'hdead);
    run_access(1'b0, {2'd2, c}, '0);
    run_access(1'b1, {2'd3, c}, 16'hbeef);
    run_access(1'b0, {2'd3, c}, '0);
    run_access(1'b0, {2'd0, c}, '0);      // Fitted banks untouched
    run_access(1'b0, {2'd1, c}, '0);

    // Second strobe lands one edge into the write
    a = pick_written();
    w = word_t'(take_bits(16));
    drive_req(1'b1, a, w);
    expect_access(1'b1, a, w);
    drive_req(1'b1, a, ~w);               // Dropped, busy is high
    finish_req();
    run_access(1'b0, a, '0);              // Still the accepted word

    repeat (8) @(posedge clk);            // Let a stray done show up
    $display("** PASS **");
    $finish;
  end

  // Run length bound
  initial begin
    #(WATCHDOG_CYC * 2 * CLK_HALF);
    stop_run("watchdog expired before the test sequence finished");
  end

endmodule

// ==== compile.f ====
mem_cfg_pkg.sv
mem_bus_pkg.sv
sram_4kx4.sv
mem_bank_decode.sv
mem_data_path.sv
mem_cycle_ctrl.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_mem_subsys
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F '** PASS **' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
